//--- bench/cache_bank_tb.sv
`timescale 1ns/1ps

module cache_bank_tb;
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;

  localparam int NUM_REQ     = 200;
  localparam int MISS_CYCLES = 20;  // Dirty eject, slowest fill and the response
  localparam int MAX_CYCLES  = NUM_REQ * MISS_CYCLES;
  localparam int TAG_POOL    = 6;   // More tags than ways, so sets overflow

  logic        CLK = 1'b0;
  logic        nRST;
  cache_req_t  req;
  cache_rsp_t  rsp;
  logic        busy;
  mem_rd_req_t mem_rd;
  mem_fill_t   mem_fill;
  mem_wr_t     mem_wr;

  logic                ref_valid [NUM_SETS_PER_BANK][NUM_WAYS];
  logic                ref_dirty [NUM_SETS_PER_BANK][NUM_WAYS];
  logic [TAG_LEN-1:0]  ref_tag   [NUM_SETS_PER_BANK][NUM_WAYS];
  int                  ref_age   [NUM_SETS_PER_BANK][NUM_WAYS];
  logic [WORD_LEN-1:0] gold      [logic [WORD_LEN-1:0]];  // Latest value of every stored word

  logic                      exp_hit;
  logic                      exp_dirty;
  logic [WORD_LEN-1:0]       exp_load;
  logic [BLOCK_ADDR_LEN-1:0] exp_victim_blk;
  logic [BLOCK_ADDR_LEN-1:0] exp_rd_blk;
  block_t                    exp_wr_words;
  logic [2:0]                wr_count;
  logic [2:0]                rd_count;
  int                        rsp_count;
  int                        cycle_count = 0;
  integer                    seed;

  cache_bank cache_bank_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .rsp      (rsp),
    .busy     (busy),
    .mem_rd   (mem_rd),
    .mem_fill (mem_fill),
    .mem_wr   (mem_wr)
  );

  mem_model mem_model_i (
    .CLK      (CLK),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr),
    .mem_fill (mem_fill)
  );

  always #20 CLK = ~CLK;

  function automatic logic [TAG_LEN-1:0] tag_from_pool(int k);
    return TAG_LEN'(32'h1b3 + k * 32'h41);
  endfunction

  function automatic logic [WORD_LEN-1:0] expected_word(logic [WORD_LEN-1:0] a);
    if (gold.exists(a)) begin
      return gold[a];
    end
    return a ^ 32'h5a5a0000;
  endfunction

  function automatic int victim_of(int s);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!ref_valid[s][w]) begin
        return w;
      end
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (ref_age[s][w] == NUM_WAYS - 1) begin
        return w;
      end
    end
    return 0;
  endfunction

  function automatic void mark_access(int s, int way);
    int old_age;
    old_age = ref_age[s][way];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (w == way) begin
        ref_age[s][w] = 0;
      end else if (ref_age[s][w] < old_age) begin
        ref_age[s][w] = ref_age[s][w] + 1;
      end
    end
  endfunction

  task automatic report_mismatch(string name, logic [WORD_LEN-1:0] got,
                                 logic [WORD_LEN-1:0] expected);
    $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, expected);
    $display("Verification failed");
    $fatal(1, "Mismatch on %s", name);
  endtask

  task automatic send_request(logic rw, int tag_sel, int s, logic [BLOCK_OFF_BIT_LEN-1:0] off,
                              logic [WORD_LEN-1:0] value);
    cache_req_t r;
    block_t     words;
    logic       hit_now;
    int         way;
    r                          = '0;
    r.valid                    = 1'b1;
    r.rw_mode                  = rw;
    r.addr.fields.tag          = tag_from_pool(tag_sel);
    r.addr.fields.index        = BLOCK_INDEX_BIT_LEN'(s);
    r.addr.fields.block_offset = off;
    r.store_value              = value;
    hit_now                    = 1'b0;
    way                        = victim_of(s);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (ref_valid[s][w] && (ref_tag[s][w] == r.addr.fields.tag)) begin
        hit_now = 1'b1;
        way     = w;
      end
    end
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      words[i] = expected_word({ref_tag[s][way], BLOCK_INDEX_BIT_LEN'(s), BLOCK_OFF_BIT_LEN'(i)});
    end
    while (busy) @(negedge CLK);
    @(posedge CLK);
    req            <= r;
    exp_hit        <= hit_now;
    exp_dirty      <= !hit_now && ref_valid[s][way] && ref_dirty[s][way];
    exp_victim_blk <= {ref_tag[s][way], BLOCK_INDEX_BIT_LEN'(s)};
    exp_rd_blk     <= r.addr.raw[WORD_LEN-1:BLOCK_OFF_BIT_LEN];
    exp_wr_words   <= words;
    exp_load       <= rw ? value : expected_word(r.addr.raw);
    @(posedge CLK);
    req.valid <= 1'b0;
    @(negedge CLK);
    while (!rsp.valid) @(negedge CLK);
    if (!hit_now) begin
      ref_valid[s][way] = 1'b1;
      ref_dirty[s][way] = 1'b0;
      ref_tag[s][way]   = r.addr.fields.tag;
    end
    if (rw) begin
      ref_dirty[s][way] = 1'b1;
      gold[r.addr.raw]  = value;
    end
    mark_access(s, way);
  endtask

  // Strobes seen since the last request
  always @(posedge CLK) begin
    if (!nRST || req.valid) begin
      wr_count <= '0;
      rd_count <= '0;
    end else begin
      if (mem_wr.valid) wr_count <= wr_count + 3'd1;
      if (mem_rd.valid) rd_count <= rd_count + 3'd1;
    end
    if (!nRST) begin
      rsp_count <= 0;
    end else if (rsp.valid) begin
      rsp_count <= rsp_count + 1;
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d responses", cycle_count, rsp_count);
      $display("Verification failed");
      $fatal(1, "Run did not finish in time");
    end
  end

  a_reset: assert property (@(posedge CLK) $rose(nRST) |->
      ({rsp.valid, busy, mem_rd.valid, mem_wr.valid} == 4'b0000))
    else report_mismatch("rsp.valid,busy,mem_rd.valid,mem_wr.valid",
                         WORD_LEN'($sampled({rsp.valid, busy, mem_rd.valid, mem_wr.valid})), '0);
  a_hit_rsp: assert property (@(posedge CLK) disable iff (!nRST)
      (req.valid && exp_hit) |=> rsp.valid)
    else report_mismatch("rsp.valid", WORD_LEN'($sampled(rsp.valid)), 1);
  a_miss_busy: assert property (@(posedge CLK) disable iff (!nRST)
      (req.valid && !exp_hit) |=> busy)
    else report_mismatch("busy", WORD_LEN'($sampled(busy)), 1);
  a_rsp_idle: assert property (@(posedge CLK) disable iff (!nRST) rsp.valid |-> !busy)
    else report_mismatch("busy", WORD_LEN'($sampled(busy)), 0);
  a_miss_end: assert property (@(posedge CLK) disable iff (!nRST) $fell(busy) |-> rsp.valid)
    else report_mismatch("rsp.valid", WORD_LEN'($sampled(rsp.valid)), 1);
  a_load: assert property (@(posedge CLK) disable iff (!nRST)
      rsp.valid |-> (rsp.load_value == exp_load))
    else report_mismatch("rsp.load_value", $sampled(rsp.load_value), $sampled(exp_load));
  a_wr_allowed: assert property (@(posedge CLK) disable iff (!nRST)
      mem_wr.valid |-> (exp_dirty && (rd_count == 3'd0) && (wr_count < 3'(BLOCK_SIZE))))
    else report_mismatch("mem_wr.valid", 1, 0);
  a_wr_burst: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_wr.valid && (wr_count < 3'(BLOCK_SIZE - 1))) |=> mem_wr.valid)
    else report_mismatch("mem_wr.valid", 0, 1);
  a_wr_addr: assert property (@(posedge CLK) disable iff (!nRST)
      mem_wr.valid |-> (mem_wr.addr.raw == {exp_victim_blk, wr_count[1:0]}))
    else report_mismatch("mem_wr.addr", $sampled(mem_wr.addr.raw),
                         $sampled({exp_victim_blk, wr_count[1:0]}));
  a_wr_word: assert property (@(posedge CLK) disable iff (!nRST)
      mem_wr.valid |-> (mem_wr.word == exp_wr_words[wr_count[1:0]]))
    else report_mismatch("mem_wr.word", $sampled(mem_wr.word),
                         $sampled(exp_wr_words[wr_count[1:0]]));
  a_rd_once: assert property (@(posedge CLK) disable iff (!nRST)
      mem_rd.valid |-> (!exp_hit && (rd_count == 3'd0)))
    else report_mismatch("mem_rd.valid", 1, 0);
  a_rd_after_wr: assert property (@(posedge CLK) disable iff (!nRST)
      mem_rd.valid |-> (wr_count == (exp_dirty ? 3'(BLOCK_SIZE) : 3'd0)))
    else report_mismatch("mem_wr count", WORD_LEN'($sampled(wr_count)),
                         $sampled(exp_dirty) ? BLOCK_SIZE : 0);
  a_rd_addr: assert property (@(posedge CLK) disable iff (!nRST)
      mem_rd.valid |-> (mem_rd.block_addr == exp_rd_blk))
    else report_mismatch("mem_rd.block_addr", WORD_LEN'($sampled(mem_rd.block_addr)),
                         WORD_LEN'($sampled(exp_rd_blk)));

  initial begin
    logic [WORD_LEN-1:0] rnd;
    seed           = 32'heda5;
    nRST           = 1'b0;
    req            = '0;
    exp_hit        = 1'b0;
    exp_dirty      = 1'b0;
    exp_load       = '0;
    exp_victim_blk = '0;
    exp_rd_blk     = '0;
    exp_wr_words   = '0;
    for (int s = 0; s < NUM_SETS_PER_BANK; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
        ref_tag[s][w]   = '0;
        ref_age[s][w]   = w;  // Reset ages follow way order
      end
    end
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    repeat (2) @(posedge CLK);
    send_request(1'b0, 0, 0, 2'd0, '0);  // Cold bank, so this load misses
    for (int n = 1; n < NUM_REQ; n++) begin
      rnd = $random(seed);
      send_request(rnd[0], int'(rnd[15:8]) % TAG_POOL, int'(rnd[16]), rnd[3:2], $random(seed));
    end
    repeat (2) @(posedge CLK);
    if (rsp_count == NUM_REQ) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Got %0d responses for %0d requests", rsp_count, NUM_REQ);
      $display("Verification failed");
      $fatal(1, "Response count mismatch");
    end
  end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model (
  input  logic                        CLK,
  input  cache_ctrl_pkg::mem_rd_req_t mem_rd,
  input  cache_ctrl_pkg::mem_wr_t     mem_wr,
  output cache_ctrl_pkg::mem_fill_t   mem_fill
);
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;

  logic [WORD_LEN-1:0] written [logic [WORD_LEN-1:0]];  // Words the bank has written back
  integer              seed;

  function automatic logic [WORD_LEN-1:0] stored_word(logic [WORD_LEN-1:0] a);
    if (written.exists(a)) begin
      return written[a];
    end
    return a ^ 32'h5a5a0000;  // Untouched words follow the whole address
  endfunction

  // Sends one block in offset order with 0 to 2 idle cycles before each word
  task automatic return_block(logic [BLOCK_ADDR_LEN-1:0] blk);
    int gap;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        mem_fill <= '0;
        @(posedge CLK);
      end
      mem_fill <= '{valid: 1'b1, word: stored_word({blk, BLOCK_OFF_BIT_LEN'(i)})};
      @(posedge CLK);
    end
    mem_fill <= '0;
  endtask

  always @(posedge CLK) begin
    if (mem_wr.valid) begin
      written[mem_wr.addr.raw] = mem_wr.word;
    end
  end

  initial begin
    seed = 32'heda5;
    mem_fill = '0;
    forever begin
      @(posedge CLK);
      if (mem_rd.valid) begin
        return_block(mem_rd.block_addr);
      end
    end
  end

endmodule

//--- common/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    VICTIM_EJECT,
    BLOCK_PULL,
    FINISH
  } miss_state_t;

  typedef struct packed {
    logic                                   valid;
    logic                                   rw_mode;  // 1 is a store
    cache_types_pkg::word_addr_t            addr;
    logic [cache_types_pkg::WORD_LEN-1:0]   store_value;
  } cache_req_t;

  typedef struct packed {
    logic                                 valid;
    logic [cache_types_pkg::WORD_LEN-1:0] load_value;
  } cache_rsp_t;

  typedef struct packed {
    logic                                       valid;
    logic [cache_types_pkg::BLOCK_ADDR_LEN-1:0] block_addr;
  } mem_rd_req_t;

  typedef struct packed {
    logic                                 valid;
    logic [cache_types_pkg::WORD_LEN-1:0] word;
  } mem_fill_t;

  typedef struct packed {
    logic                                 valid;
    cache_types_pkg::word_addr_t          addr;
    logic [cache_types_pkg::WORD_LEN-1:0] word;
  } mem_wr_t;

  typedef struct packed {
    cache_req_t                           req;
    logic [cache_types_pkg::WAYS_LEN-1:0] victim_way;
    logic                                 victim_dirty;
  } mshr_reg;

  // Finished refill handed to the bank store for one cycle
  typedef struct packed {
    logic                                            valid;
    logic [cache_types_pkg::BLOCK_INDEX_BIT_LEN-1:0] index;
    logic [cache_types_pkg::WAYS_LEN-1:0]            way;
    logic [cache_types_pkg::TAG_LEN-1:0]             tag;
    cache_types_pkg::block_t                         block;
    logic                                            dirty;
    logic                                            age_reset;
  } fill_t;

endpackage

//--- common/cache_types_pkg.sv
package cache_types_pkg;

  localparam int WORD_LEN            = 32;
  localparam int NUM_SETS_PER_BANK   = 8;
  localparam int NUM_WAYS            = 4;
  localparam int BLOCK_SIZE          = 4;  // Words per block
  localparam int BLOCK_INDEX_BIT_LEN = 3;
  localparam int WAYS_LEN            = 2;
  localparam int BLOCK_OFF_BIT_LEN   = 2;
  localparam int TAG_LEN             = 27;

  // Tag and set index together name one block in memory
  localparam int BLOCK_ADDR_LEN = TAG_LEN + BLOCK_INDEX_BIT_LEN;

  typedef logic [BLOCK_SIZE-1:0][WORD_LEN-1:0] block_t;

  typedef struct packed {
    logic [TAG_LEN-1:0]             tag;
    logic [BLOCK_INDEX_BIT_LEN-1:0] index;
    logic [BLOCK_OFF_BIT_LEN-1:0]   block_offset;
  } addr_fields_t;

  // Cache side reads the fields, memory side reads the raw word
  typedef union packed {
    logic [WORD_LEN-1:0] raw;
    addr_fields_t        fields;
  } word_addr_t;

  typedef struct packed {
    logic               valid;
    logic               dirty;
    logic [TAG_LEN-1:0] tag;
    block_t             block;
  } cache_frame;

  typedef cache_frame [NUM_WAYS-1:0] cache_set;

  // Ages of one set, 0 is the most recently used way
  typedef logic [NUM_WAYS-1:0][WAYS_LEN-1:0] lru_ages_t;

endpackage

//--- design/bank_store.sv
`timescale 1ns/1ps

module bank_store (
  input  logic                                 CLK,
  input  logic                                 nRST,
  input  cache_ctrl_pkg::cache_req_t           req,
  input  logic                                 hit,
  input  logic [cache_types_pkg::WAYS_LEN-1:0] hit_way,
  input  cache_ctrl_pkg::fill_t                fill,
  output cache_types_pkg::cache_set            set_frames,
  output cache_types_pkg::lru_ages_t           ages,
  output cache_ctrl_pkg::cache_rsp_t           rsp
);
  import cache_types_pkg::*;

  logic [NUM_SETS_PER_BANK-1:0][NUM_WAYS-1:0] valid_q;
  logic [NUM_SETS_PER_BANK-1:0][NUM_WAYS-1:0] dirty_q;
  logic [TAG_LEN-1:0]             tag_q  [NUM_SETS_PER_BANK][NUM_WAYS];
  block_t                         data_q [NUM_SETS_PER_BANK][NUM_WAYS];
  lru_ages_t                      ages_q [NUM_SETS_PER_BANK];
  logic [BLOCK_INDEX_BIT_LEN-1:0] idx;
  logic [BLOCK_OFF_BIT_LEN-1:0]   off;
  logic [BLOCK_OFF_BIT_LEN-1:0]   pend_off;
  logic [BLOCK_INDEX_BIT_LEN-1:0] acc_set;
  logic [WAYS_LEN-1:0]            acc_way;
  logic                           rsp_valid;
  logic [WORD_LEN-1:0]            rsp_word;

  // Accessed way drops to 0, younger ways age by one
  function automatic lru_ages_t touch(lru_ages_t cur, logic [WAYS_LEN-1:0] way);
    lru_ages_t nxt;
    nxt = cur;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (w == int'(way)) begin
        nxt[w] = '0;
      end else if (cur[w] < cur[way]) begin
        nxt[w] = cur[w] + 1'b1;
      end
    end
    return nxt;
  endfunction

  function automatic logic ages_perm(lru_ages_t a);
    logic [NUM_WAYS-1:0] seen;
    seen = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      seen[a[w]] = 1'b1;
    end
    return &seen;
  endfunction

  assign idx = req.addr.fields.index;
  assign off = req.addr.fields.block_offset;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      set_frames[w].valid = valid_q[idx][w];
      set_frames[w].dirty = dirty_q[idx][w];
      set_frames[w].tag   = tag_q[idx][w];
      set_frames[w].block = data_q[idx][w];
    end
  end

  assign ages    = ages_q[idx];
  assign acc_set = fill.valid ? fill.index : idx;
  assign acc_way = fill.valid ? fill.way : hit_way;
  assign rsp     = '{valid: rsp_valid, load_value: rsp_word};

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      rsp_valid <= 1'b0;
      for (int s = 0; s < NUM_SETS_PER_BANK; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          ages_q[s][w] <= WAYS_LEN'(w);
        end
      end
    end else begin
      rsp_valid <= hit || fill.valid;
      if (hit) begin
        ages_q[idx] <= touch(ages_q[idx], hit_way);
        if (req.rw_mode) begin
          dirty_q[idx][hit_way] <= 1'b1;
        end
      end
      if (fill.valid) begin
        valid_q[fill.index][fill.way] <= 1'b1;
        dirty_q[fill.index][fill.way] <= fill.dirty;
        if (fill.age_reset) begin
          ages_q[fill.index] <= touch(ages_q[fill.index], fill.way);
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (req.valid) begin
      pend_off <= off;  // Kept for the load word of a refill
    end
    if (hit) begin
      if (req.rw_mode) begin
        data_q[idx][hit_way][off] <= req.store_value;
        rsp_word                  <= req.store_value;
      end else begin
        rsp_word <= data_q[idx][hit_way][off];
      end
    end
    if (fill.valid) begin
      tag_q[fill.index][fill.way]  <= fill.tag;
      data_q[fill.index][fill.way] <= fill.block;
      rsp_word                     <= fill.block[pend_off];
    end
  end

  for (genvar s = 0; s < NUM_SETS_PER_BANK; s++) begin : g_age_chk
    assert property (@(posedge CLK) disable iff (!nRST) ages_perm(ages_q[s]))
      else $error("Set %0d ages are not distinct so the LRU way is ambiguous", s);
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    (hit || fill.valid) |=> (ages_q[$past(acc_set)][$past(acc_way)] == '0))
    else $error("Accessed way of set %0d kept a nonzero age", $past(acc_set));

  assert property (@(posedge CLK) disable iff (!nRST)
    fill.valid |=> (valid_q[$past(fill.index)][$past(fill.way)] &&
                    (tag_q[$past(fill.index)][$past(fill.way)] == $past(fill.tag)) &&
                    (data_q[$past(fill.index)][$past(fill.way)] == $past(fill.block))))
    else $error("Refilled frame does not hold the latched tag and block");

  assert property (@(posedge CLK) disable iff (!nRST)
    (hit && req.rw_mode) |=>
      (data_q[$past(idx)][$past(hit_way)][$past(off)] == $past(req.store_value)))
    else $error("Store hit did not update its word");

endmodule

//--- design/cache_bank.sv
`timescale 1ns/1ps

module cache_bank (
  input  logic                        CLK,
  input  logic                        nRST,
  input  cache_ctrl_pkg::cache_req_t  req,
  output cache_ctrl_pkg::cache_rsp_t  rsp,
  output logic                        busy,
  output cache_ctrl_pkg::mem_rd_req_t mem_rd,
  input  cache_ctrl_pkg::mem_fill_t   mem_fill,
  output cache_ctrl_pkg::mem_wr_t     mem_wr
);
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;

  cache_set            set_frames;
  lru_ages_t           ages;
  logic                hit;
  logic                miss;
  logic [WAYS_LEN-1:0] hit_way;
  fill_t               fill;

  hit_path hit_path_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .req        (req),
    .set_frames (set_frames),
    .hit        (hit),
    .hit_way    (hit_way),
    .miss       (miss)
  );

  miss_fsm miss_fsm_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .req        (req),
    .miss       (miss),
    .set_frames (set_frames),
    .ages       (ages),
    .mem_rd     (mem_rd),
    .mem_fill   (mem_fill),
    .mem_wr     (mem_wr),
    .fill       (fill),
    .busy       (busy)
  );

  bank_store bank_store_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .req        (req),
    .hit        (hit),
    .hit_way    (hit_way),
    .fill       (fill),
    .set_frames (set_frames),
    .ages       (ages),
    .rsp        (rsp)
  );

endmodule

//--- design/hit_path.sv
`timescale 1ns/1ps

module hit_path (
  input  logic                                 CLK,
  input  logic                                 nRST,
  input  cache_ctrl_pkg::cache_req_t           req,
  input  cache_types_pkg::cache_set            set_frames,
  output logic                                 hit,
  output logic [cache_types_pkg::WAYS_LEN-1:0] hit_way,
  output logic                                 miss
);
  import cache_types_pkg::*;

  logic [NUM_WAYS-1:0] match;

  // True when two valid frames of the set carry the same tag
  function automatic logic dup_tags(cache_set frames);
    logic dup;
    dup = 1'b0;
    for (int a = 0; a < NUM_WAYS; a++) begin
      for (int b = a + 1; b < NUM_WAYS; b++) begin
        if (frames[a].valid && frames[b].valid && (frames[a].tag == frames[b].tag)) begin
          dup = 1'b1;
        end
      end
    end
    return dup;
  endfunction

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = set_frames[w].valid && (set_frames[w].tag == req.addr.fields.tag);
    end
  end

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (match[w]) begin
        hit_way = WAYS_LEN'(w);  // At most one way matches
      end
    end
  end

  assign hit  = req.valid && (|match);
  assign miss = req.valid && !(|match);

  // A duplicate tag would mean a refill installed a block the set already held
  assert property (@(posedge CLK) disable iff (!nRST) !dup_tags(set_frames))
    else $error("Set %0d holds the same tag in two valid ways", req.addr.fields.index);

endmodule

//--- files.f
common/cache_types_pkg.sv
common/cache_ctrl_pkg.sv
design/hit_path.sv
miss_handler/victim_select.sv
miss_handler/miss_fsm.sv
design/bank_store.sv
design/cache_bank.sv
bench/mem_model.sv
bench/cache_bank_tb.sv

//--- miss_handler/miss_fsm.sv
`timescale 1ns/1ps

module miss_fsm (
  input  logic                          CLK,
  input  logic                          nRST,
  input  cache_ctrl_pkg::cache_req_t    req,
  input  logic                          miss,
  input  cache_types_pkg::cache_set     set_frames,
  input  cache_types_pkg::lru_ages_t    ages,
  output cache_ctrl_pkg::mem_rd_req_t   mem_rd,
  input  cache_ctrl_pkg::mem_fill_t     mem_fill,
  output cache_ctrl_pkg::mem_wr_t       mem_wr,
  output cache_ctrl_pkg::fill_t         fill,
  output logic                          busy
);
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;

  miss_state_t                  state_q;
  miss_state_t                  state_d;
  logic [BLOCK_OFF_BIT_LEN-1:0] count_FSM;
  logic [BLOCK_OFF_BIT_LEN-1:0] next_count_FSM;
  logic                         last_word;
  logic [WAYS_LEN-1:0]          victim_way;
  logic                         victim_dirty;
  logic                         mem_rd_valid;
  mshr_reg                      mshr;
  cache_frame                   victim_q;
  block_t                       pull_buf;
  block_t                       fill_block;
  word_addr_t                   wr_addr;

  victim_select victim_select_i (
    .set_frames (set_frames),
    .ages       (ages),
    .victim_way (victim_way)
  );

  assign victim_dirty = set_frames[victim_way].valid && set_frames[victim_way].dirty;
  assign last_word    = (count_FSM == BLOCK_OFF_BIT_LEN'(BLOCK_SIZE - 1));

  always_comb begin
    state_d        = state_q;
    next_count_FSM = count_FSM;
    case (state_q)
      IDLE: begin
        if (miss) begin
          state_d = victim_dirty ? VICTIM_EJECT : BLOCK_PULL;
        end
      end
      VICTIM_EJECT: begin
        next_count_FSM = count_FSM + 1'b1;  // One word leaves per cycle
        if (last_word) begin
          state_d = BLOCK_PULL;
        end
      end
      BLOCK_PULL: begin
        if (mem_fill.valid) begin
          next_count_FSM = count_FSM + 1'b1;
          if (last_word) begin
            state_d = FINISH;
          end
        end
      end
      default: state_d = IDLE;  // FINISH lasts exactly one cycle
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q      <= IDLE;
      count_FSM    <= '0;
      mem_rd_valid <= 1'b0;
    end else begin
      state_q      <= state_d;
      count_FSM    <= next_count_FSM;
      mem_rd_valid <= (state_d == BLOCK_PULL) && (state_q != BLOCK_PULL);  // Entry pulse
    end
  end

  always_ff @(posedge CLK) begin
    if ((state_q == IDLE) && miss) begin
      mshr.req          <= req;
      mshr.victim_way   <= victim_way;
      mshr.victim_dirty <= victim_dirty;
      victim_q          <= set_frames[victim_way];
    end
    if ((state_q == BLOCK_PULL) && mem_fill.valid) begin
      pull_buf[count_FSM] <= mem_fill.word;  // Words arrive in offset order
    end
  end

  always_comb begin
    fill_block = pull_buf;
    if (mshr.req.rw_mode) begin
      fill_block[mshr.req.addr.fields.block_offset] = mshr.req.store_value;
    end
  end

  always_comb begin
    wr_addr.fields.tag          = victim_q.tag;
    wr_addr.fields.index        = mshr.req.addr.fields.index;
    wr_addr.fields.block_offset = count_FSM;
  end

  assign mem_wr = '{valid: (state_q == VICTIM_EJECT) && mshr.victim_dirty,
                    addr:  wr_addr,
                    word:  victim_q.block[count_FSM]};

  assign mem_rd = '{valid: mem_rd_valid,
                    block_addr: mshr.req.addr.raw[WORD_LEN-1:BLOCK_OFF_BIT_LEN]};

  assign fill = '{valid:     (state_q == FINISH),
                  index:     mshr.req.addr.fields.index,
                  way:       mshr.victim_way,
                  tag:       mshr.req.addr.fields.tag,
                  block:     fill_block,
                  dirty:     mshr.req.rw_mode,
                  age_reset: 1'b1};

  assign busy = (state_q != IDLE);

  assert property (@(posedge CLK) disable iff (!nRST) busy |-> !req.valid)
    else $error("Request sent while a miss is outstanding");

  // The counter may only return to 0 from its last word, and only as the state moves on
  assert property (@(posedge CLK) disable iff (!nRST)
    (($past(count_FSM) != '0) && (count_FSM == '0)) |-> ($past(last_word) && (state_q != $past(state_q))))
    else $error("count_FSM wrapped before %0d words were counted", BLOCK_SIZE);

endmodule

//--- miss_handler/victim_select.sv
`timescale 1ns/1ps

module victim_select (
  input  cache_types_pkg::cache_set            set_frames,
  input  cache_types_pkg::lru_ages_t           ages,
  output logic [cache_types_pkg::WAYS_LEN-1:0] victim_way
);
  import cache_types_pkg::*;

  logic found_invalid;

  always_comb begin
    found_invalid = 1'b0;
    victim_way    = '0;

    // Lowest numbered empty way wins
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found_invalid && !set_frames[w].valid) begin
        found_invalid = 1'b1;
        victim_way    = WAYS_LEN'(w);
      end
    end

    // A full set gives up its least recently used way
    if (!found_invalid) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (ages[w] == WAYS_LEN'(NUM_WAYS - 1)) begin
          victim_way = WAYS_LEN'(w);
        end
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Builds the cache bank testbench with Verilator and runs it from the project root.
# The run passes only if the simulation prints the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_bank_tb -f files.f -o sim_cache_bank && \
  ./obj_dir/sim_cache_bank | tee /dev/stderr | grep -x "Verification passed" > /dev/null && \
  echo "RUN PASS" || { echo "RUN FAIL"; exit 1; }
